// ==== board_view.f ====
+incdir+verilog
verilog/board_pkg.sv
verilog/wb_pkg.sv
verilog/i2s_mic_receiver.sv
verilog/sample_store_master.sv
verilog/display_scan_master.sv
verilog/wb_arbiter.sv
verilog/sample_ram.sv
verilog/seg_hold.sv
verilog/board_view_top.sv
verification/board_view_tb.sv

// ==== Bender.yml ====
package:
  name: board_view

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/board_pkg.sv
      - verilog/wb_pkg.sv
      - verilog/i2s_mic_receiver.sv
      - verilog/sample_store_master.sv
      - verilog/display_scan_master.sv
      - verilog/wb_arbiter.sv
      - verilog/sample_ram.sv
      - verilog/seg_hold.sv
      - verilog/board_view_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/board_view_tb.sv

// ==== verification/board_view_testdata.txt ====
// Columns: 24-bit mic sample, expected displayed word (bits 23:8), ring slot (sw for the check)
// Line 0 is test 2, lines 1-4 test 3, lines 5-17 test 4, lines 18-19 test 5
12a4c3 12a4 0
0345f1 0345 1
7ffe10 7ffe 2
a0bd77 a0bd 3
5c1a02 5c1a 4
2468ac 2468 5
13579b 1357 6
0f0f0f 0f0f 7
3c3c81 3c3c 8
e6b2d4 e6b2 9
48c0de 48c0 a
1e9b3a 1e9b b
70a5c6 70a5 c
0c0ffe 0c0f d
55aa11 55aa e
3fd012 3fd0 f
6e1bf9 6e1b 0
0a7c35 0a7c 1
c38e47 c38e 2
4d92b0 4d92 3

// ==== verification/board_view_tb.sv ====
`default_nettype none

`include "board_view_config.svh"

module board_view_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int  NUM_LINES    = 20;
    localparam int  RAND_SAMPLES = 8;
    localparam int  CHECK_FRAMES = 4;                     // Three full scans and a read
    localparam int  FRAME_CLOCKS = 128 * `BV_SCK_DIV;     // 64 SCK periods
    localparam real CLK_NS       = 100.0;
    // Every sample, a ring turn before each aligned burst and the wait of each check
    localparam int  RUN_FRAMES   = NUM_LINES + RAND_SAMPLES + 4 * `BV_RING_DEPTH
                                 + 16 * CHECK_FRAMES;
    localparam real RUN_NS       = 4.0 * RUN_FRAMES * FRAME_CLOCKS * CLK_NS;

    typedef struct packed
    {
        board_pkg::sample_t   sample;
        logic [15:0]          word;                       // Expected displayed word
        logic                 has_slot;
        board_pkg::ring_idx_t slot;
    } mic_item_t;

    typedef struct packed
    {
        board_pkg::hex_t   hex3;
        board_pkg::hex_t   hex2;
        board_pkg::hex_t   hex1;
        board_pkg::hex_t   hex0;
        board_pkg::digit_t dp;
    } display_t;

    logic                 clk;
    logic                 rst;
    board_pkg::ring_idx_t sw;
    logic                 mic_sd;
    logic                 mic_sck;
    logic                 mic_ws;
    board_pkg::hex_t      hex0;
    board_pkg::hex_t      hex1;
    board_pkg::hex_t      hex2;
    board_pkg::hex_t      hex3;
    board_pkg::digit_t    ledr_dp;

    logic [23:0]          tdata [0:3 * NUM_LINES - 1];
    mic_item_t            mic_queue [$];
    mic_item_t            cur_item;
    board_pkg::sample_t   ring_sample [`BV_RING_DEPTH];   // Ring as the mic model wrote it
    logic [15:0]          ring_word [`BV_RING_DEPTH];
    board_pkg::ring_idx_t next_slot = '0;
    board_pkg::ring_idx_t cur_slot  = '0;
    int                   frames_done = 0;
    int                   bit_pos     = 0;
    logic                 sck_prev    = 1'b0;
    logic                 ws_prev     = 1'b0;
    logic [31:0]          rng;
    int                   errors      = 0;
    int                   test_base   = 0;
    int                   passed      = 0;
    int                   failed      = 0;

    board_view_top board_view_top_i
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .sw      ( sw      ),
        .mic_sd  ( mic_sd  ),
        .mic_sck ( mic_sck ),
        .mic_ws  ( mic_ws  ),
        .hex0    ( hex0    ),
        .hex1    ( hex1    ),
        .hex2    ( hex2    ),
        .hex3    ( hex3    ),
        .ledr_dp ( ledr_dp )
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_NS / 2.0) clk = ~clk;
    end

    // --------------------
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic board_pkg::hex_t hex_pattern(input logic [3:0] value);
        case (value)                                      // Active low, bit 0 is a
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    function automatic mic_item_t line_item(input int line);
        mic_item_t item;
        item.sample   = tdata[3 * line];
        item.word     = tdata[3 * line + 1][15:0];
        item.has_slot = 1'b1;
        item.slot     = tdata[3 * line + 2][3:0];
        return item;
    endfunction

    task automatic expect_display(input logic [15:0] word, output display_t disp);
        disp.hex0 = hex_pattern(word[3:0]);
        disp.hex1 = hex_pattern(word[7:4]);
        disp.hex2 = hex_pattern(word[11:8]);
        disp.hex3 = hex_pattern(word[15:12]);
        disp.dp   = {word[15], 3'b000};                   // Negative sample lights digit 3
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            errors = errors + 1;
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_base)
        begin
            passed = passed + 1;
            $display("test %s: ok", name);
        end
        else
        begin
            failed = failed + 1;
            $display("test %s: %0d errors", name, errors - test_base);
        end
        test_base = errors;
    endtask

    task automatic wait_frames(input int count);
        int target;
        target = frames_done + count;
        while (frames_done < target)
            @(negedge clk);
    endtask

    // Returns once the frame that took the last queued word is complete
    task automatic wait_queue_sent();
        while (mic_queue.size() != 0)
            @(negedge clk);
        wait_frames(1);
    endtask

    task automatic send_lines(input int first, input int count);
        while (next_slot != tdata[3 * first + 2][3:0])    // Start at the first line's slot
            @(negedge clk);
        for (int i = 0; i < count; i++)
            mic_queue.push_back(line_item(first + i));
        wait_queue_sent();
    endtask

    task automatic check_display(input board_pkg::ring_idx_t slot);
        display_t exp;
        @(negedge clk);
        sw = slot;
        wait_frames(CHECK_FRAMES);
        expect_display(ring_word[slot], exp);
        check_value(hex0, exp.hex0, $sformatf("hex0 for slot %0d", slot));
        check_value(hex1, exp.hex1, $sformatf("hex1 for slot %0d", slot));
        check_value(hex2, exp.hex2, $sformatf("hex2 for slot %0d", slot));
        check_value(hex3, exp.hex3, $sformatf("hex3 for slot %0d", slot));
        check_value(ledr_dp, exp.dp, $sformatf("ledr_dp for slot %0d", slot));
    endtask

    // --------------------
    // Microphone model

    always @(negedge clk)
    begin
        if (sck_prev && !mic_sck)
        begin
            bit_pos = (ws_prev && !mic_ws) ? 0 : bit_pos + 1;   // WS fall starts the frame
            // WS is high for the second 32 SCK periods of a frame
            check_value(mic_ws, (bit_pos >= 32) && (bit_pos < 64), "mic_ws at SCK fall");
            if (bit_pos == 1)
            begin
                if (mic_queue.size() > 0)
                    cur_item = mic_queue.pop_front();
                else
                begin
                    // Idle frames repeat the slot's word so the history stays put
                    cur_item.sample   = ring_sample[next_slot];
                    cur_item.word     = ring_word[next_slot];
                    cur_item.has_slot = 1'b0;
                    cur_item.slot     = next_slot;
                end
                if (cur_item.has_slot)
                    check_value(next_slot, cur_item.slot, "ring slot of queued sample");
                cur_slot  = next_slot;
                next_slot = next_slot + 4'd1;
            end
            if (bit_pos >= 1 && bit_pos <= 24)
                mic_sd <= cur_item.sample[24 - bit_pos];  // MSB first after the delay bit
            else
                mic_sd <= 1'b0;
            if (bit_pos == 25)
            begin
                ring_sample[cur_slot] = cur_item.sample;
                ring_word[cur_slot]   = cur_item.word;
                frames_done           = frames_done + 1;
            end
        end
        sck_prev = mic_sck;
        ws_prev  = mic_ws;
    end

    // --------------------
    // Tests

    initial
    begin
        mic_item_t item;
        rst    = 1'b1;
        sw     = '0;
        mic_sd = 1'b0;
        rng    = 32'd59671;
        for (int i = 0; i < `BV_RING_DEPTH; i++)
        begin
            ring_sample[i] = '0;
            ring_word[i]   = '0;
        end
        $readmemh("verification/board_view_testdata.txt", tdata);
        mic_queue.push_back(line_item(0));                // Rides the first frame
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_value(hex0, 7'h7f, "hex0 after reset");
        check_value(hex1, 7'h7f, "hex1 after reset");
        check_value(hex2, 7'h7f, "hex2 after reset");
        check_value(hex3, 7'h7f, "hex3 after reset");
        check_value(ledr_dp, 4'h0, "ledr_dp after reset");
        check_value(mic_sck, 1'b0, "mic_sck after reset");
        check_value(mic_ws, 1'b0, "mic_ws after reset");
        end_test("1 reset blank");

        wait_queue_sent();
        check_display(4'd0);
        end_test("2 single sample");

        send_lines(1, 4);
        for (int s = 0; s <= 5; s++)
            check_display(s[3:0]);                        // Slot 5 is still empty
        end_test("3 arrival order");

        send_lines(5, 13);
        check_display(4'd0);
        check_display(4'd1);
        end_test("4 ring wrap");

        send_lines(18, 2);
        check_display(4'd2);
        check_display(4'd3);
        end_test("5 sign point");

        for (int i = 0; i < RAND_SAMPLES; i++)
        begin
            rng           = xorshift32(rng);
            item.sample   = rng[23:0];
            item.word     = rng[23:8];
            item.has_slot = 1'b0;
            item.slot     = '0;
            mic_queue.push_back(item);
        end
        while (mic_queue.size() != 0)                     // Switch moves while samples stream
        begin
            @(negedge clk);
            rng = xorshift32(rng);
            sw  = rng[3:0];
        end
        wait_frames(1);
        for (int i = 0; i < 3; i++)
        begin
            rng = xorshift32(rng);
            check_display(rng[3:0]);
        end
        end_test("6 random switch");

        $display("tests passed: %0d, failed: %0d, errors: %0d", passed, failed, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(RUN_NS);
        $display("The run timed out before all tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/board_view_top.sv ====
`default_nettype none

module board_view_top
(
    input  logic                 clk,
    input  logic                 rst,
    input  board_pkg::ring_idx_t sw,
    input  logic                 mic_sd,
    output logic                 mic_sck,
    output logic                 mic_ws,
    output board_pkg::hex_t      hex0,
    output board_pkg::hex_t      hex1,
    output board_pkg::hex_t      hex2,
    output board_pkg::hex_t      hex3,
    output board_pkg::digit_t    ledr_dp      // Decimal points on the red LEDs
);

    logic               sample_ready;
    board_pkg::sample_t sample;
    wb_pkg::wb_req_t    store_req;
    wb_pkg::wb_rsp_t    store_rsp;
    wb_pkg::wb_req_t    view_req;
    wb_pkg::wb_rsp_t    view_rsp;
    wb_pkg::wb_req_t    ram_req;
    wb_pkg::wb_rsp_t    ram_rsp;
    board_pkg::seg_t    abcdefgh;
    board_pkg::digit_t  digit;

    // --------------------
    // Capture path

    i2s_mic_receiver i2s_mic_receiver_i
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sd           ( mic_sd       ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .sample_ready ( sample_ready ),
        .sample       ( sample       )
    );

    sample_store_master sample_store_master_i
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sample_ready ( sample_ready ),
        .sample       ( sample       ),
        .wb_req       ( store_req    ),
        .wb_rsp       ( store_rsp    )
    );

    // --------------------
    // Shared ring

    wb_arbiter wb_arbiter_i
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .store_req ( store_req ),
        .view_req  ( view_req  ),
        .store_rsp ( store_rsp ),
        .view_rsp  ( view_rsp  ),
        .ram_req   ( ram_req   ),
        .ram_rsp   ( ram_rsp   )
    );

    sample_ram sample_ram_i
    (
        .clk    ( clk     ),
        .rst    ( rst     ),
        .wb_req ( ram_req ),
        .wb_rsp ( ram_rsp )
    );

    // --------------------
    // Display path

    display_scan_master display_scan_master_i
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .sw       ( sw       ),
        .wb_req   ( view_req ),
        .wb_rsp   ( view_rsp ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    seg_hold seg_hold_i
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .hex0     ( hex0     ),
        .hex1     ( hex1     ),
        .hex2     ( hex2     ),
        .hex3     ( hex3     ),
        .dp       ( ledr_dp  )
    );

endmodule

`default_nettype wire

// ==== verilog/seg_hold.sv ====
`default_nettype none

module seg_hold
(
    input  logic              clk,
    input  logic              rst,
    input  board_pkg::seg_t   abcdefgh,
    input  board_pkg::digit_t digit,
    output board_pkg::hex_t   hex0,
    output board_pkg::hex_t   hex1,
    output board_pkg::hex_t   hex2,
    output board_pkg::hex_t   hex3,
    output board_pkg::digit_t dp
);

    board_pkg::seg_t hgfedcba;
    board_pkg::hex_t hex_q [4];

    // Board segment 0 is a, so the bit order flips
    always_comb
        for (int i = 0; i < 8; i++)
            hgfedcba[i] = abcdefgh[7 - i];

    // Each digit keeps its pattern until its next scan slot
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            for (int i = 0; i < 4; i++)
                hex_q[i] <= '1;            // Blank
            dp <= '0;
        end
        else
            for (int i = 0; i < 4; i++)
                if (digit[i])
                begin
                    hex_q[i] <= ~hgfedcba[6:0];   // Active low
                    dp[i]    <= hgfedcba[7];
                end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];

endmodule

`default_nettype wire

// ==== verilog/sample_ram.sv ====
`default_nettype none

`include "board_view_config.svh"

module sample_ram
(
    input  logic            clk,
    input  logic            rst,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp
);

    board_pkg::sample_t mem [`BV_RING_DEPTH];
    logic               ack_q;
    wb_pkg::wb_dat_t    rd_q;
    logic               access;

    assign access = wb_req.cyc && wb_req.stb && !ack_q;   // New request only

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            ack_q <= 1'b0;
            rd_q  <= '0;
            for (int i = 0; i < `BV_RING_DEPTH; i++)
                mem[i] <= '0;              // Empty slots read as zero
        end
        else
        begin
            ack_q <= access;
            if (access)
            begin
                if (wb_req.we)
                    mem[wb_req.adr] <= wb_req.dat;
                rd_q <= mem[wb_req.adr];
            end
        end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_q;

endmodule

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
`default_nettype none

module wb_arbiter
(
    input  logic            clk,
    input  logic            rst,
    input  wb_pkg::wb_req_t store_req,
    input  wb_pkg::wb_req_t view_req,
    output wb_pkg::wb_rsp_t store_rsp,
    output wb_pkg::wb_rsp_t view_rsp,
    output wb_pkg::wb_req_t ram_req,
    input  wb_pkg::wb_rsp_t ram_rsp
);

    typedef enum logic [1:0]
    {
        own_none,
        own_store,
        own_view
    } owner_t;

    owner_t owner_q;
    owner_t owner;
    logic   busy;

    // A cycle stays with its owner until that master drops cyc
    always_comb
    begin
        busy  = ((owner_q == own_store) && store_req.cyc)
             || ((owner_q == own_view) && view_req.cyc);
        owner = owner_q;
        if (!busy)
        begin
            if (store_req.cyc)
                owner = own_store;         // Store wins a tie
            else if (view_req.cyc)
                owner = own_view;
            else
                owner = own_none;
        end
    end

    always_ff @(posedge clk or posedge rst)
        if (rst)
            owner_q <= own_none;
        else
            owner_q <= owner;

    always_comb
        case (owner)
            own_store: ram_req = store_req;
            own_view:  ram_req = view_req;
            default:   ram_req = '0;
        endcase

    always_comb
    begin
        store_rsp     = ram_rsp;
        view_rsp      = ram_rsp;
        store_rsp.ack = ram_rsp.ack && (owner == own_store);
        view_rsp.ack  = ram_rsp.ack && (owner == own_view);
    end

endmodule

`default_nettype wire

// ==== verilog/display_scan_master.sv ====
`default_nettype none

`include "board_view_config.svh"

module display_scan_master
(
    input  logic                 clk,
    input  logic                 rst,
    input  board_pkg::ring_idx_t sw,
    output wb_pkg::wb_req_t      wb_req,
    input  wb_pkg::wb_rsp_t      wb_rsp,
    output board_pkg::seg_t      abcdefgh,
    output board_pkg::digit_t    digit
);

    typedef enum logic
    {
        st_scan,
        st_fetch
    } state_t;

    state_t             state_q;
    logic [15:0]        tick_cnt;
    logic [1:0]         dig_idx;
    logic               scan_start;
    wb_pkg::wb_adr_t    adr_q;
    board_pkg::sample_t word_q;            // Last word read from the ring
    logic [3:0]         nibble;
    logic [6:0]         shape;

    function automatic logic [6:0] hex_shape(input logic [3:0] value);
        case (value)                       // abcdefg
            4'h0: hex_shape = 7'b1111110;
            4'h1: hex_shape = 7'b0110000;
            4'h2: hex_shape = 7'b1101101;
            4'h3: hex_shape = 7'b1111001;
            4'h4: hex_shape = 7'b0110011;
            4'h5: hex_shape = 7'b1011011;
            4'h6: hex_shape = 7'b1011111;
            4'h7: hex_shape = 7'b1110000;
            4'h8: hex_shape = 7'b1111111;
            4'h9: hex_shape = 7'b1111011;
            4'ha: hex_shape = 7'b1110111;
            4'hb: hex_shape = 7'b0011111;
            4'hc: hex_shape = 7'b1001110;
            4'hd: hex_shape = 7'b0111101;
            4'he: hex_shape = 7'b1001111;
            default: hex_shape = 7'b1000111;
        endcase
    endfunction

    // --------------------
    // Scan timing

    assign scan_start = (tick_cnt == '0) && (dig_idx == 2'd0);

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            tick_cnt <= '0;
            dig_idx  <= '0;
        end
        else if (tick_cnt == 16'(`BV_SCAN_TICKS - 1))
        begin
            tick_cnt <= '0;
            dig_idx  <= dig_idx + 2'd1;    // Digit 0 to digit 3
        end
        else
            tick_cnt <= tick_cnt + 16'd1;

    // --------------------
    // Read of the selected slot

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            state_q <= st_scan;
            adr_q   <= '0;
            word_q  <= '0;
        end
        else
            case (state_q)
                st_scan:
                    if (scan_start)
                    begin
                        state_q <= st_fetch;
                        adr_q   <= sw;     // Held for the whole cycle
                    end
                st_fetch:
                    if (wb_rsp.ack)
                    begin
                        state_q <= st_scan;
                        word_q  <= wb_rsp.dat;
                    end
                default:
                    state_q <= st_scan;
            endcase

    always_comb
    begin
        wb_req     = '0;
        wb_req.cyc = (state_q == st_fetch);
        wb_req.stb = (state_q == st_fetch);
        wb_req.adr = adr_q;
    end

    // --------------------
    // Digit output

    // Digit 0 is the low nibble of bits 23:8
    assign nibble = word_q[8 + 4 * dig_idx +: 4];
    assign shape  = hex_shape(nibble);

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            digit    <= '0;
            abcdefgh <= '0;
        end
        else
        begin
            digit    <= board_pkg::digit_t'(4'b0001 << dig_idx);
            abcdefgh <= {shape, (dig_idx == 2'd3) && word_q[23]};   // Point marks negative
        end

endmodule

`default_nettype wire

// ==== verilog/sample_store_master.sv ====
`default_nettype none

module sample_store_master
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample_ready,
    input  board_pkg::sample_t   sample,
    output wb_pkg::wb_req_t      wb_req,
    input  wb_pkg::wb_rsp_t      wb_rsp
);

    typedef enum logic
    {
        st_idle,
        st_write
    } state_t;

    state_t               state_q;
    board_pkg::ring_idx_t wr_ptr;
    board_pkg::sample_t   pend_q;          // Sample waiting for its write

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            state_q <= st_idle;
            wr_ptr  <= '0;
        end
        else
            case (state_q)
                st_idle:
                    if (sample_ready)
                        state_q <= st_write;
                st_write:
                    if (wb_rsp.ack)
                    begin
                        state_q <= st_idle;
                        wr_ptr  <= wr_ptr + 4'd1;   // Wraps from 15 to 0
                    end
                default:
                    state_q <= st_idle;
            endcase

    // A newer sample replaces one still pending
    always_ff @(posedge clk)
        if (sample_ready)
            pend_q <= sample;

    always_comb
    begin
        wb_req     = '0;
        wb_req.cyc = (state_q == st_write);
        wb_req.stb = (state_q == st_write);
        wb_req.we  = 1'b1;
        wb_req.adr = wr_ptr;
        wb_req.dat = pend_q;
    end

endmodule

`default_nettype wire

// ==== verilog/i2s_mic_receiver.sv ====
`default_nettype none

`include "board_view_config.svh"

module i2s_mic_receiver
(
    input  logic               clk,
    input  logic               rst,
    input  logic               sd,
    output logic               sck,
    output logic               ws,
    output logic               sample_ready,
    output board_pkg::sample_t sample
);

    logic [7:0]         div_cnt;       // Clocks within an SCK half period
    logic [5:0]         bit_cnt;       // SCK periods within a frame
    logic               sck_edge;
    logic               sck_rise;
    logic               sck_fall;
    logic               left_bit;
    board_pkg::sample_t shift_q;

    assign sck_edge = (div_cnt == 8'(`BV_SCK_DIV - 1));
    assign sck_rise = sck_edge & ~sck;
    assign sck_fall = sck_edge & sck;

    // One-bit I2S delay, so the MSB arrives in period 1 of the WS-low half
    assign left_bit = (bit_cnt >= 6'd1) && (bit_cnt <= 6'd24);

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            div_cnt      <= '0;
            sck          <= 1'b0;
            bit_cnt      <= '0;
            sample_ready <= 1'b0;
        end
        else
        begin
            div_cnt <= sck_edge ? 8'd0 : div_cnt + 8'd1;

            if (sck_edge)
                sck <= ~sck;

            if (sck_fall)
                bit_cnt <= bit_cnt + 6'd1;        // WS follows bit 5

            sample_ready <= sck_rise && (bit_cnt == 6'd24);   // Last left bit in
        end

    always_ff @(posedge clk)
        if (sck_rise && left_bit)
            shift_q <= {shift_q[22:0], sd};       // MSB first

    assign ws     = bit_cnt[5];
    assign sample = shift_q;

endmodule

`default_nettype wire

// ==== verilog/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    typedef logic [3:0]  wb_adr_t;     // Word address
    typedef logic [23:0] wb_dat_t;     // Data word

    // --------------------
    // Master to slave

    typedef struct packed
    {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;                  // Write data
    } wb_req_t;

    // --------------------
    // Slave to master

    typedef struct packed
    {
        logic    ack;
        wb_dat_t dat;                  // Read data, valid with ack
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // Microphone sample in two's complement, kept as a plain vector
    typedef logic [23:0] sample_t;

    typedef logic [7:0]  seg_t;        // Segments abcdefgh, active high
    typedef logic [3:0]  digit_t;      // One-hot digit select
    typedef logic [6:0]  hex_t;        // Board HEX pattern, active low

    typedef logic [3:0]  ring_idx_t;   // Slot in the sample ring

endpackage

`default_nettype wire

// ==== verilog/board_view_config.svh ====
`ifndef BOARD_VIEW_CONFIG_SVH
`define BOARD_VIEW_CONFIG_SVH

// --------------------
// Board clock

`define BV_CLK_MHZ      50     // System clock rate

// --------------------
// Microphone and display timing

`define BV_SCK_DIV      2      // Clocks per SCK half period
`define BV_SCAN_TICKS   64     // Clocks each digit stays selected

// Sample history size
`define BV_RING_DEPTH   16

`endif
